// ==== rtl/cr16IsaPkg.sv ====
// Word width is fixed at 16 by the CR-16 encoding; flag layout matches the PSR low bits
package cr16IsaPkg;

	// Data path width
	parameter int dataWidth = 16;
	// Bits needed for a shift amount of 0 to 15
	parameter int shiftAmtWidth = $clog2(dataWidth);
	// PSR bits above the five condition flags
	parameter int reservedWidth = dataWidth - 5;

	typedef logic [dataWidth-1:0] word_t;

	// ALU operation encoding from the decoder
	typedef enum logic [2:0] {
		opAdd,
		opSub,
		opCmp,
		opAnd,
		opOr,
		opXor,
		opMov,
		// Low byte of source moved into high byte
		opMovHigh
	} aluOp_t;

	// Processor status word, flags in the low five bits
	typedef struct packed {
		logic [reservedWidth-1:0] reserved;
		logic negative;
		logic zero;
		// Signed overflow
		logic flag;
		logic low;
		logic carry;
	} psrFlags_t;

	// Shift control as carried in the source operand
	typedef struct packed {
		logic [dataWidth-shiftAmtWidth-3:0] unused;
		logic arithmetic;
		logic rightShift;
		logic [shiftAmtWidth-1:0] amount;
	} shiftCtrl_t;

	// Same word seen by the ALU as data and by the shifter as control
	typedef union packed {
		word_t data;
		shiftCtrl_t shift;
	} srcOperand_u;

endpackage

// ==== rtl/cr16CtrlPkg.sv ====
// Control word is driven by an external decoder every cycle; register count is fixed at 16
package cr16CtrlPkg;

	// Architectural register count
	parameter int regCount = 16;

	// Register index
	typedef logic [$clog2(regCount)-1:0] regAddr_t;

	// Execute stage control from the decoder
	typedef struct packed {
		// Destination operand taken from pc
		logic pcInstruction;
		// Source from register, else immediate
		logic rTypeInstruction;
		// Result from shifter, else ALU
		logic shiftInstruction;
		// Write result back to dstAddr
		logic regWrite;
		// Load ALU flags into the PSR
		logic flagSet;
		cr16IsaPkg::aluOp_t aluOp;
	} execCtrl_t;

endpackage

// ==== rtl/regFile.sv ====
// Reads are combinational with no write bypass; a write shows up on reads the next cycle
`timescale 1ns/1ps

module regFile
	import cr16IsaPkg::*;
	import cr16CtrlPkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     regWrite,
	input  regAddr_t srcAddr,
	input  regAddr_t dstAddr,
	input  word_t    wrData,
	output word_t    srcValue,
	output word_t    dstValue
);

	// Register array
	word_t regs [regCount];

	// Single write port at the destination address
	always_ff @(posedge clk) begin
		if (!reset) begin
			// Clear every register
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[dstAddr] <= wrData;
		end
	end

	// Source operand read
	assign srcValue = regs[srcAddr];
	// Destination operand read, also the write target
	assign dstValue = regs[dstAddr];

	// Write port must see a known address and data
	assertWriteKnown : assert property (
		@(posedge clk) disable iff (!reset)
		regWrite |-> !$isunknown({dstAddr, wrData})
	) else $error("regFile write with unknown address or data");

endmodule

// ==== rtl/aluCore.sv ====
// Purely combinational; carry holds the borrow on subtract and compare, reserved flags read zero
`timescale 1ns/1ps

module aluCore
	import cr16IsaPkg::*;
(
	input  word_t       dstOperand,
	input  srcOperand_u srcOperand,
	input  aluOp_t      aluOp,
	output word_t       aluResult,
	output psrFlags_t   aluFlags
);

	// Source seen as a plain data word
	word_t srcData;
	// Sum or difference with carry/borrow on top
	logic [dataWidth:0] arith;
	logic carryOut;
	logic overflow;

	assign srcData = srcOperand.data;

	// Result and arithmetic side flags
	always_comb begin
		arith     = '0;
		aluResult = '0;
		carryOut  = 1'b0;
		overflow  = 1'b0;
		unique case (aluOp)
			opAdd: begin
				arith     = {1'b0, dstOperand} + {1'b0, srcData};
				aluResult = arith[dataWidth-1:0];
				carryOut  = arith[dataWidth];
				// Same sign in, different sign out
				overflow  = (dstOperand[dataWidth-1] == srcData[dataWidth-1]) &&
					(aluResult[dataWidth-1] != dstOperand[dataWidth-1]);
			end
			opSub, opCmp: begin
				// Top bit is the borrow
				arith     = {1'b0, dstOperand} - {1'b0, srcData};
				aluResult = arith[dataWidth-1:0];
				carryOut  = arith[dataWidth];
				// Signs differ and result sign flips away from dst
				overflow  = (dstOperand[dataWidth-1] != srcData[dataWidth-1]) &&
					(aluResult[dataWidth-1] != dstOperand[dataWidth-1]);
			end
			opAnd:     aluResult = dstOperand & srcData;
			opOr:      aluResult = dstOperand | srcData;
			opXor:     aluResult = dstOperand ^ srcData;
			opMov:     aluResult = srcData;
			// low byte to high byte, low byte cleared
			opMovHigh: aluResult = {srcData[7:0], 8'h00};
			default:   aluResult = '0;
		endcase
	end

	// Flag word
	always_comb begin
		aluFlags          = '0;
		aluFlags.carry    = carryOut;
		aluFlags.flag     = overflow;
		// Unsigned compare for every operation
		aluFlags.low      = dstOperand < srcData;
		aluFlags.zero     = aluResult == '0;
		// Signed less-than on compare, result sign otherwise
		if (aluOp == opCmp) begin
			aluFlags.negative = $signed(dstOperand) < $signed(srcData);
		end else begin
			aluFlags.negative = aluResult[dataWidth-1];
		end
	end

	// Decoder must always present a valid operation
	always_comb begin
		assertOpKnown : assert (!$isunknown(aluOp))
			else $error("aluCore operation is unknown");
	end

endmodule

// ==== rtl/barrelShifter.sv ====
// Shift control comes from the low six bits of the source operand; amounts run 0 to 15
`timescale 1ns/1ps

module barrelShifter
	import cr16IsaPkg::*;
(
	input  word_t       shiftInput,
	input  srcOperand_u srcOperand,
	output word_t       shiftResult
);

	// Decoded shift control
	shiftCtrl_t shiftCtrl;
	logic fillBit;
	// Input with fill bits above for right shifts
	logic [2*dataWidth-1:0] extended;
	logic [2*dataWidth-1:0] rightShifted;

	assign shiftCtrl = srcOperand.shift;

	// Sign fill only on arithmetic right shifts
	assign fillBit      = shiftCtrl.arithmetic & shiftInput[dataWidth-1];
	assign extended     = {{dataWidth{fillBit}}, shiftInput};
	assign rightShifted = extended >> shiftCtrl.amount;

	// Direction select
	assign shiftResult = shiftCtrl.rightShift ? rightShifted[dataWidth-1:0]
		: shiftInput << shiftCtrl.amount;

	// Direction and amount must be known
	always_comb begin
		assertCtrlKnown : assert (!$isunknown({shiftCtrl.rightShift, shiftCtrl.amount}))
			else $error("barrelShifter control is unknown");
	end

endmodule

// ==== rtl/statusRegister.sv ====
// Flags update one cycle after the operation and only when flagSet is high
`timescale 1ns/1ps

module statusRegister
	import cr16IsaPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      flagSet,
	input  psrFlags_t aluFlags,
	output psrFlags_t outputFlags
);

	// Load on flagSet, hold otherwise
	always_ff @(posedge clk) begin
		if (!reset) begin
			outputFlags <= '0;
		end else if (flagSet) begin
			outputFlags <= aluFlags;
		end
	end

	// Reserved PSR bits never pick up a value from the ALU
	assertReservedZero : assert property (
		@(posedge clk) disable iff (!reset)
		outputFlags.reserved == '0
	) else $error("statusRegister reserved bits set");

endmodule

// ==== rtl/aluRegFile.sv ====
// One operation per clock from decoder controls; no handshake, no stall, no write bypass
`timescale 1ns/1ps

module aluRegFile
	import cr16IsaPkg::*;
	import cr16CtrlPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  execCtrl_t ctrl,
	input  regAddr_t  srcAddr,
	input  regAddr_t  dstAddr,
	input  word_t     immd,
	input  word_t     pc,
	output word_t     resultData,
	output psrFlags_t outputFlags
);

	// Register read values
	word_t srcValue;
	word_t dstValue;
	// Operands after the pc and immediate muxes
	word_t dstOperand;
	srcOperand_u srcOperand;
	// Unit results
	word_t aluResult;
	word_t shiftResult;
	psrFlags_t aluFlags;

	// pc replaces the destination register for pc-relative ops
	assign dstOperand = ctrl.pcInstruction ? pc : dstValue;

	// Register source for R-type, immediate otherwise
	assign srcOperand.data = ctrl.rTypeInstruction ? srcValue : immd;

	// Result select, also the write-back data
	assign resultData = ctrl.shiftInstruction ? shiftResult : aluResult;

	regFile i_regFile (
		.clk      (clk),
		.reset    (reset),
		.regWrite (ctrl.regWrite),
		.srcAddr  (srcAddr),
		.dstAddr  (dstAddr),
		.wrData   (resultData),
		.srcValue (srcValue),
		.dstValue (dstValue)
	);

	aluCore i_aluCore (
		.dstOperand (dstOperand),
		.srcOperand (srcOperand),
		.aluOp      (ctrl.aluOp),
		.aluResult  (aluResult),
		.aluFlags   (aluFlags)
	);

	// Shifts the destination operand
	barrelShifter i_barrelShifter (
		.shiftInput  (dstOperand),
		.srcOperand  (srcOperand),
		.shiftResult (shiftResult)
	);

	statusRegister i_statusRegister (
		.clk         (clk),
		.reset       (reset),
		.flagSet     (ctrl.flagSet),
		.aluFlags    (aluFlags),
		.outputFlags (outputFlags)
	);

endmodule

// ==== test/aluRegFileTb.sv ====
// One operation per clock, no bypass; outputs sampled on the falling edge, stops at first error
`timescale 1ns/1ps

module aluRegFileTb
	import cr16IsaPkg::*;
	import cr16CtrlPkg::*;
;

	logic      clk;
	logic      reset;
	execCtrl_t ctrl;
	regAddr_t  srcAddr;
	regAddr_t  dstAddr;
	word_t     immd;
	word_t     pc;
	word_t     resultData;
	psrFlags_t outputFlags;

	// Reference copy of the architectural state
	word_t     modelRegs [regCount];
	psrFlags_t modelFlags;

	aluRegFile i_aluRegFile (
		.clk         (clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.srcAddr     (srcAddr),
		.dstAddr     (dstAddr),
		.immd        (immd),
		.pc          (pc),
		.resultData  (resultData),
		.outputFlags (outputFlags)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	// Reset low for three cycles
	initial begin
		clk   = 1'b0;
		reset = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b1;
	end

	task automatic compareWord(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("FAIL %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Word mismatch");
		end
	endtask

	task automatic compareFlags(input string name, input psrFlags_t actual,
		input psrFlags_t expected);
		if (actual !== expected) begin
			$display("FAIL %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Flag mismatch");
		end
	endtask

	// ALU result and flags straight from the flag rules, using integer range checks
	function automatic word_t refAlu(input word_t d, input word_t s, input aluOp_t op,
		output psrFlags_t f);
		int ud;
		int us;
		int sd;
		int ss;
		word_t r;
		ud = int'(d);
		us = int'(s);
		sd = int'($signed(d));
		ss = int'($signed(s));
		f  = '0;
		r  = '0;
		case (op)
			opAdd: begin
				r       = word_t'(ud + us);
				f.carry = (ud + us) > 65535;
				f.flag  = (sd + ss) > 32767 || (sd + ss) < -32768;
			end
			opSub, opCmp: begin
				r = word_t'(ud - us);
				// Borrow
				f.carry = ud < us;
				f.flag  = (sd - ss) > 32767 || (sd - ss) < -32768;
			end
			opAnd:     r = d & s;
			opOr:      r = d | s;
			opXor:     r = d ^ s;
			opMov:     r = s;
			opMovHigh: r = {s[7:0], 8'h00};
		endcase
		f.low      = d < s;
		f.zero     = r == '0;
		f.negative = (op == opCmp) ? (sd < ss) : r[dataWidth-1];
		return r;
	endfunction

	// One place per step, fill decided bit by bit
	function automatic word_t refShift(input word_t v, input logic arith, input logic right,
		input int amt);
		word_t r;
		r = v;
		for (int i = 0; i < amt; i++) begin
			if (right) begin
				r = {arith & r[dataWidth-1], r[dataWidth-1:1]};
			end else begin
				r = {r[dataWidth-2:0], 1'b0};
			end
		end
		return r;
	endfunction

	function automatic execCtrl_t makeCtrl(input logic pcI, input logic rType, input logic shift,
		input logic wr, input logic fs, input aluOp_t op);
		execCtrl_t c;
		c.pcInstruction    = pcI;
		c.rTypeInstruction = rType;
		c.shiftInstruction = shift;
		c.regWrite         = wr;
		c.flagSet          = fs;
		c.aluOp            = op;
		return c;
	endfunction

	function automatic word_t randWord();
		return word_t'($urandom());
	endfunction

	function automatic regAddr_t randAddr();
		return regAddr_t'($urandom());
	endfunction

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		while (reset !== 1'b1 && cycles <= 20) begin
			@(posedge clk);
			cycles++;
		end
		if (reset !== 1'b1) begin
			$display("Timeout: reset was never released");
			$display("*** FAILED ***");
			$fatal(1, "Reset timeout");
		end
	endtask

	// Drive one operation, check result now and flags of the previous op
	task automatic executeOp(input execCtrl_t c, input regAddr_t s, input regAddr_t d,
		input word_t im, input word_t pcVal);
		word_t dstOp;
		word_t srcOp;
		word_t aluRes;
		word_t expResult;
		psrFlags_t aluF;
		@(posedge clk);
		ctrl    <= c;
		srcAddr <= s;
		dstAddr <= d;
		immd    <= im;
		pc      <= pcVal;
		@(negedge clk);
		dstOp  = c.pcInstruction ? pcVal : modelRegs[d];
		srcOp  = c.rTypeInstruction ? modelRegs[s] : im;
		aluRes = refAlu(dstOp, srcOp, c.aluOp, aluF);
		// Shift control: arithmetic bit 5, right bit 4, amount 3:0
		if (c.shiftInstruction) begin
			expResult = refShift(dstOp, srcOp[5], srcOp[4], int'(srcOp[3:0]));
		end else begin
			expResult = aluRes;
		end
		compareWord("resultData", resultData, expResult);
		compareFlags("outputFlags", outputFlags, modelFlags);
		// State seen from the next cycle on
		if (c.regWrite) begin
			modelRegs[d] = expResult;
		end
		if (c.flagSet) begin
			modelFlags = aluF;
		end
	endtask

	task automatic checkResetState();
		// Away from the clock edge
		@(negedge clk);
		compareFlags("outputFlags", outputFlags, psrFlags_t'(0));
		for (int i = 0; i < regCount; i++) begin
			executeOp(makeCtrl(0, 1, 0, 0, 0, opMov), regAddr_t'(i), regAddr_t'(i), '0, '0);
		end
	endtask

	// Even registers by full move, odd ones by high byte then OR of the low byte
	task automatic loadRegisters();
		word_t v;
		for (int i = 0; i < regCount; i++) begin
			v = randWord();
			if (i % 2 == 0) begin
				executeOp(makeCtrl(0, 0, 0, 1, 0, opMov), '0, regAddr_t'(i), v, '0);
			end else begin
				executeOp(makeCtrl(0, 0, 0, 1, 0, opMovHigh), '0, regAddr_t'(i), v >> 8, '0);
				executeOp(makeCtrl(0, 0, 0, 1, 0, opOr), '0, regAddr_t'(i), v & 16'h00ff, '0);
			end
		end
		for (int i = 0; i < regCount; i++) begin
			executeOp(makeCtrl(0, 1, 0, 0, 0, opMov), regAddr_t'(i), regAddr_t'(i), '0, '0);
		end
	endtask

	task automatic checkRandomOps();
		for (int n = 0; n < 64; n++) begin
			for (int k = 0; k < 8; k++) begin
				executeOp(makeCtrl(0, 1, 0, 1'($urandom_range(1, 0)), 1, aluOp_t'(3'(k))),
					randAddr(), randAddr(), randWord(), randWord());
			end
		end
	endtask

	// Register 15 holds the shift control for the register variant
	task automatic checkShifts();
		word_t sc;
		regAddr_t d;
		for (int r = 0; r < 2; r++) begin
			for (int a = 0; a < 2; a++) begin
				for (int amt = 0; amt < 16; amt++) begin
					sc = {randWord() & 16'hffc0} | word_t'(a << 5) | word_t'(r << 4) | word_t'(amt);
					d  = regAddr_t'($urandom_range(14, 0));
					executeOp(makeCtrl(0, 0, 1, 0, 0, opAdd), '0, d, sc, '0);
					executeOp(makeCtrl(0, 0, 0, 1, 0, opMov), '0, 4'd15, sc, '0);
					executeOp(makeCtrl(0, 1, 1, 1, 0, opAdd), 4'd15, d, randWord(), '0);
					// Fresh value into the shifted register
					executeOp(makeCtrl(0, 0, 0, 1, 0, opMov), '0, d, randWord(), '0);
				end
			end
		end
	endtask

	task automatic checkPcAdd();
		for (int n = 0; n < 8; n++) begin
			executeOp(makeCtrl(1, 0, 0, 0, 1, opAdd), randAddr(), randAddr(), randWord(),
				randWord());
		end
		for (int i = 0; i < regCount; i++) begin
			executeOp(makeCtrl(0, 1, 0, 0, 0, opMov), regAddr_t'(i), regAddr_t'(i), '0, '0);
		end
	endtask

	task automatic checkFlagHoldAndWriteTiming();
		executeOp(makeCtrl(0, 1, 0, 0, 1, opCmp), 4'd1, 4'd2, '0, '0);
		// Flags must hold through these
		for (int n = 0; n < 8; n++) begin
			executeOp(makeCtrl(0, 0, 0, 0, 0, aluOp_t'(3'(n))), '0, randAddr(), randWord(), '0);
		end
		// Back-to-back increments, each sees the previous write only in the next cycle
		executeOp(makeCtrl(0, 0, 0, 1, 0, opMov), '0, 4'd3, 16'hfffe, '0);
		for (int n = 0; n < 3; n++) begin
			executeOp(makeCtrl(0, 0, 0, 1, 0, opAdd), '0, 4'd3, 16'h0001, '0);
		end
		executeOp(makeCtrl(0, 1, 0, 0, 0, opMov), 4'd3, 4'd3, '0, '0);
		// Final idle cycle checks flags of the last op
		executeOp(makeCtrl(0, 0, 0, 0, 0, opAdd), '0, '0, '0, '0);
	endtask

	initial begin
		void'($urandom(32'h603f_4934));
		ctrl       = '0;
		srcAddr    = '0;
		dstAddr    = '0;
		immd       = '0;
		pc         = '0;
		modelFlags = '0;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0;
		end
		waitResetRelease();
		checkResetState();
		loadRegisters();
		checkRandomOps();
		checkShifts();
		checkPcAdd();
		checkFlagHoldAndWriteTiming();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== flist.f ====
rtl/cr16IsaPkg.sv
rtl/cr16CtrlPkg.sv
rtl/regFile.sv
rtl/aluCore.sv
rtl/barrelShifter.sv
rtl/statusRegister.sv
rtl/aluRegFile.sv
test/aluRegFileTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module aluRegFileTb -o simv

# Exit status of the run is not used; the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi
